// File: verilog/soc_pkg.sv
package soc_pkg;

   // Bus widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 16;
   localparam int STRB_W = 4;
   localparam int BYTE_W = DATA_W / STRB_W;

   // Slave select lives in the top address bits
   localparam int SEL_W   = 3;
   localparam int SEL_LSB = ADDR_W - SEL_W;

   // Slave indices, 5 to 7 unmapped
   localparam logic [SEL_W-1:0] SLV_REMAP = 3'd0;
   localparam logic [SEL_W-1:0] SLV_BOOT  = 3'd1;
   localparam logic [SEL_W-1:0] SLV_RAM   = 3'd2;
   localparam logic [SEL_W-1:0] SLV_UART  = 3'd3;
   localparam logic [SEL_W-1:0] SLV_SRST  = 3'd4;

   // UART word offsets, address bits [4:2]
   localparam int UART_OFS_W = 3;

   localparam logic [UART_OFS_W-1:0] UART_DIV     = 3'd0;
   localparam logic [UART_OFS_W-1:0] UART_TXDATA  = 3'd1;
   localparam logic [UART_OFS_W-1:0] UART_TXBUSY  = 3'd2;
   localparam logic [UART_OFS_W-1:0] UART_RXDATA  = 3'd3;
   localparam logic [UART_OFS_W-1:0] UART_RXVALID = 3'd4;

endpackage

// File: verilog/mem_bus_if.sv
`timescale 1ns/10ps

interface mem_bus_if import soc_pkg::*; ();

   logic              valid;
   logic              ready;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wdata;
   logic [STRB_W-1:0] wstrb;
   logic [DATA_W-1:0] rdata;

   // Zero strobe means read
   modport master (
      output valid, addr, wdata, wstrb,
      input  ready, rdata
   );

   modport slave (
      input  valid, addr, wdata, wstrb,
      output ready, rdata
   );

endinterface

// File: verilog/sp_ram.sv
`timescale 1ns/10ps

module sp_ram import soc_pkg::*; #(
   parameter int ADDR_W_WORDS = 8
) (
   input  logic     clk,
   input  logic     reset,
   mem_bus_if.slave bus
);

   localparam int DEPTH = 1 << ADDR_W_WORDS;

   logic [DATA_W-1:0]       mem [DEPTH];
   logic [ADDR_W_WORDS-1:0] word_addr;
   logic                    access;

   // Upper address bits alias
   assign word_addr = bus.addr[ADDR_W_WORDS+1:2];

   // Ready gap keeps a held valid from acking twice
   assign access = bus.valid && !bus.ready;

   always_ff @(posedge clk) begin
      if (access) begin
         for (int i = 0; i < STRB_W; i++) begin
            if (bus.wstrb[i])
               mem[word_addr][i*BYTE_W +: BYTE_W] <= bus.wdata[i*BYTE_W +: BYTE_W];
         end
         bus.rdata <= mem[word_addr];
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         bus.ready <= 1'b0;
      else
         bus.ready <= access;
   end

endmodule

// File: verilog/uart_core.sv
`timescale 1ns/10ps

module uart_core import soc_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   mem_bus_if.slave bus,
   output logic     txd,
   output logic     rts,
   input  logic     rxd,
   input  logic     cts
);

   localparam int               DIV_W     = 16;
   localparam logic [DIV_W-1:0] DIV_RESET = 16'd15;

   logic [UART_OFS_W-1:0] reg_ofs;
   logic                  access;
   logic                  wr_en;
   logic                  rd_en;
   logic [DIV_W-1:0]      div;

   logic                  tx_pending;
   logic                  tx_active;
   logic                  tx_busy;
   logic                  tx_load;
   logic [7:0]            tx_buf;
   logic [9:0]            tx_shift;
   logic [DIV_W-1:0]      tx_cnt;
   logic [3:0]            tx_bit;

   logic [2:0]            rxd_sync;
   logic                  rx_in;
   logic                  rx_fall;
   logic                  rx_active;
   logic                  rx_sample;
   logic                  rx_done;
   logic [DIV_W-1:0]      rx_cnt;
   logic [3:0]            rx_bit;
   logic [7:0]            rx_shift;
   logic [7:0]            rx_buf;
   logic                  rx_valid;

   assign reg_ofs = bus.addr[4:2];
   assign access  = bus.valid && !bus.ready;
   assign wr_en   = access && (bus.wstrb != '0);
   assign rd_en   = access && (bus.wstrb == '0);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         bus.ready <= 1'b0;
         div       <= DIV_RESET;
      end else begin
         bus.ready <= access;
         if (wr_en && reg_ofs == UART_DIV)
            div <= bus.wdata[DIV_W-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         case (reg_ofs)
            UART_DIV:     bus.rdata <= DATA_W'(div);
            UART_TXDATA:  bus.rdata <= DATA_W'(tx_buf);
            UART_TXBUSY:  bus.rdata <= DATA_W'(tx_busy);
            UART_RXDATA:  bus.rdata <= DATA_W'(rx_buf);
            UART_RXVALID: bus.rdata <= DATA_W'(rx_valid);
            default:      bus.rdata <= '0;
         endcase
      end
   end

   // Transmitter, writes while busy are dropped
   assign tx_busy = tx_pending || tx_active;
   assign tx_load = wr_en && (reg_ofs == UART_TXDATA) && !tx_busy;

   always_ff @(posedge clk) begin
      if (tx_load)
         tx_buf <= bus.wdata[7:0];
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         tx_pending <= 1'b0;
         tx_active  <= 1'b0;
         tx_shift   <= '1;
         tx_cnt     <= '0;
         tx_bit     <= '0;
      end else if (tx_active) begin
         if (tx_cnt >= div) begin
            tx_cnt   <= '0;
            tx_shift <= {1'b1, tx_shift[9:1]};
            tx_bit   <= tx_bit + 4'd1;
            // Stop bit done
            if (tx_bit == 4'd9)
               tx_active <= 1'b0;
         end else begin
            tx_cnt <= tx_cnt + 1'b1;
         end
      end else if (tx_pending && cts) begin
         tx_pending <= 1'b0;
         tx_active  <= 1'b1;
         tx_shift   <= {1'b1, tx_buf, 1'b0};
         tx_cnt     <= '0;
         tx_bit     <= '0;
      end else if (tx_load) begin
         tx_pending <= 1'b1;
      end
   end

   assign txd = tx_shift[0];

   // Receiver
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         rxd_sync <= '1;
      else
         rxd_sync <= {rxd_sync[1:0], rxd};
   end

   assign rx_in     = rxd_sync[1];
   assign rx_fall   = rxd_sync[2] && !rxd_sync[1];
   assign rx_sample = rx_active && (rx_cnt == '0);
   assign rx_done   = rx_sample && (rx_bit == 4'd9) && rx_in;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rx_active <= 1'b0;
         rx_cnt    <= '0;
         rx_bit    <= '0;
         rx_valid  <= 1'b0;
      end else begin
         if (!rx_active) begin
            if (rx_fall) begin
               // First sample lands mid start bit
               rx_active <= 1'b1;
               rx_cnt    <= div >> 1;
               rx_bit    <= '0;
            end
         end else if (rx_cnt != '0) begin
            rx_cnt <= rx_cnt - 1'b1;
         end else begin
            rx_cnt <= div;
            rx_bit <= rx_bit + 4'd1;
            // Start bit gone high again is a glitch
            if ((rx_bit == 4'd0 && rx_in) || rx_bit == 4'd9)
               rx_active <= 1'b0;
         end

         if (rx_done)
            rx_valid <= 1'b1;
         else if (rd_en && reg_ofs == UART_RXDATA)
            rx_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rx_sample && rx_bit >= 4'd1 && rx_bit <= 4'd8)
         rx_shift <= {rx_in, rx_shift[7:1]};
      if (rx_done)
         rx_buf <= rx_shift;
   end

   // Full buffer holds off the sender
   assign rts = !rx_valid;

endmodule

// File: verilog/bus_decoder.sv
`timescale 1ns/10ps

module bus_decoder import soc_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   mem_bus_if.slave  cpu,
   mem_bus_if.master boot,
   mem_bus_if.master ram,
   mem_bus_if.master uart,
   output logic      cpu_reset
);

   logic             boot_flag;
   logic             srst_pulse;
   logic             srst_write;
   logic             local_ready;
   logic             local_sel;
   logic             cpu_write;
   logic [SEL_W-1:0] sel_raw;
   logic [SEL_W-1:0] sel;

   assign sel_raw   = cpu.addr[ADDR_W-1:SEL_LSB];
   assign cpu_write = |cpu.wstrb;

   // Region 0 follows the boot flag
   always_comb begin
      if (sel_raw == SLV_REMAP)
         sel = boot_flag ? SLV_BOOT : SLV_RAM;
      else
         sel = sel_raw;
   end

   // Reset register and unmapped regions are answered here
   assign local_sel = !(sel == SLV_BOOT || sel == SLV_RAM || sel == SLV_UART);

   assign boot.valid = cpu.valid && (sel == SLV_BOOT);
   assign boot.addr  = cpu.addr;
   assign boot.wdata = cpu.wdata;
   assign boot.wstrb = cpu.wstrb;

   assign ram.valid  = cpu.valid && (sel == SLV_RAM);
   assign ram.addr   = cpu.addr;
   assign ram.wdata  = cpu.wdata;
   assign ram.wstrb  = cpu.wstrb;

   assign uart.valid = cpu.valid && (sel == SLV_UART);
   assign uart.addr  = cpu.addr;
   assign uart.wdata = cpu.wdata;
   assign uart.wstrb = cpu.wstrb;

   always_comb begin
      case (sel)
         SLV_BOOT: begin
            cpu.ready = boot.ready;
            cpu.rdata = boot.rdata;
         end
         SLV_RAM: begin
            cpu.ready = ram.ready;
            cpu.rdata = ram.rdata;
         end
         SLV_UART: begin
            cpu.ready = uart.ready;
            cpu.rdata = uart.rdata;
         end
         default: begin
            cpu.ready = local_ready;
            cpu.rdata = '0;
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         local_ready <= 1'b0;
      else
         local_ready <= cpu.valid && local_sel && !local_ready;
   end

   // Acked write to the reset register
   assign srst_write = local_ready && (sel == SLV_SRST) && cpu_write;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         boot_flag  <= 1'b1;
         srst_pulse <= 1'b0;
      end else begin
         srst_pulse <= srst_write;
         if (srst_write)
            boot_flag <= 1'b0;
      end
   end

   assign cpu_reset = reset | srst_pulse;

endmodule

// File: verilog/soc_top.sv
`timescale 1ns/10ps

module soc_top import soc_pkg::*; #(
   parameter int BOOT_ADDR_W = 8,
   parameter int RAM_ADDR_W  = 10
) (
   input  logic              clk,
   input  logic              reset,

   // External bus master
   input  logic              mem_valid,
   input  logic [ADDR_W-1:0] mem_addr,
   input  logic [DATA_W-1:0] mem_wdata,
   input  logic [STRB_W-1:0] mem_wstrb,
   output logic              mem_ready,
   output logic [DATA_W-1:0] mem_rdata,

   output logic              cpu_reset,

   // Serial side
   output logic              uart_txd,
   output logic              uart_rts,
   input  logic              uart_rxd,
   input  logic              uart_cts
);

   mem_bus_if cpu_bus ();
   mem_bus_if boot_bus ();
   mem_bus_if ram_bus ();
   mem_bus_if uart_bus ();

   assign cpu_bus.valid = mem_valid;
   assign cpu_bus.addr  = mem_addr;
   assign cpu_bus.wdata = mem_wdata;
   assign cpu_bus.wstrb = mem_wstrb;
   assign mem_ready     = cpu_bus.ready;
   assign mem_rdata     = cpu_bus.rdata;

   bus_decoder decoder_i (
      .clk       (clk),
      .reset     (reset),
      .cpu       (cpu_bus),
      .boot      (boot_bus),
      .ram       (ram_bus),
      .uart      (uart_bus),
      .cpu_reset (cpu_reset)
   );

   // Boot RAM, region 1 and region 0 while booting
   sp_ram #(
      .ADDR_W_WORDS (BOOT_ADDR_W)
   ) boot_mem (
      .clk   (clk),
      .reset (reset),
      .bus   (boot_bus)
   );

   // Main RAM, region 2 and region 0 after software reset
   sp_ram #(
      .ADDR_W_WORDS (RAM_ADDR_W)
   ) main_mem (
      .clk   (clk),
      .reset (reset),
      .bus   (ram_bus)
   );

   uart_core uart_i (
      .clk   (clk),
      .reset (reset),
      .bus   (uart_bus),
      .txd   (uart_txd),
      .rts   (uart_rts),
      .rxd   (uart_rxd),
      .cts   (uart_cts)
   );

endmodule

// File: tb/tb_soc.sv
`timescale 1ns/10ps

module tb_soc import soc_pkg::*; ();

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 16;
   localparam int BUS_CYCLES   = 16;
   localparam int POLL_READS   = 250;
   // A poll read takes at most four cycles
   localparam int POLL_CYCLES  = POLL_READS * 4;
   localparam int MAX_VEC      = 64;
   localparam int NAME_W       = 8 * 24;
   localparam int OP_W         = 8 * 4;

   logic              clk;
   logic              reset;
   logic              mem_valid;
   logic [ADDR_W-1:0] mem_addr;
   logic [DATA_W-1:0] mem_wdata;
   logic [STRB_W-1:0] mem_wstrb;
   logic              mem_ready;
   logic [DATA_W-1:0] mem_rdata;
   logic              cpu_reset;
   logic              uart_txd;
   logic              uart_rts;
   logic              uart_cts;

   // One vector table entry per line of the file
   logic [NAME_W-1:0] v_name [MAX_VEC];
   logic [OP_W-1:0]   v_op   [MAX_VEC];
   logic [ADDR_W-1:0] v_addr [MAX_VEC];
   logic [DATA_W-1:0] v_data [MAX_VEC];
   logic [STRB_W-1:0] v_strb [MAX_VEC];
   logic [DATA_W-1:0] v_exp  [MAX_VEC];

   int          fd;
   int          n_vec;
   int          pass_count;
   int          fail_count;
   bit          vectors_loaded;

   // Serial loopback
   soc_top dut_i (
      .*,
      .uart_rxd (uart_txd)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic bus_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb, output logic [DATA_W-1:0] rdata,
                             output bit ok);
      int cycles;
      @(negedge clk);
      mem_valid = 1'b1;
      mem_addr  = addr;
      mem_wdata = data;
      mem_wstrb = strb;
      ok        = 1'b0;
      rdata     = '0;
      for (cycles = 0; cycles < BUS_CYCLES && !ok; cycles++) begin
         @(posedge clk);
         ok    = mem_ready;
         rdata = mem_rdata;
      end
      // Drop valid before the slave could ack again
      @(negedge clk);
      mem_valid = 1'b0;
      if (!ok)
         $display("No ready from the bus within %0d cycles at address %h", BUS_CYCLES, addr);
   endtask

   task automatic run_vector(input int i);
      logic [DATA_W-1:0] act;
      bit                ok;
      bit                checked;
      int                reads;
      act     = '0;
      ok      = 1'b1;
      checked = 1'b1;
      case (v_op[i])
         OP_W'("wr"): begin
            bus_access(v_addr[i], v_data[i], v_strb[i], act, ok);
            checked = 1'b0;
         end
         OP_W'("rd"): begin
            bus_access(v_addr[i], '0, '0, act, ok);
         end
         OP_W'("poll"): begin
            act = ~v_exp[i];
            for (reads = 0; ok && act !== v_exp[i] && reads < POLL_READS; reads++)
               bus_access(v_addr[i], '0, '0, act, ok);
            if (ok && act !== v_exp[i]) begin
               $display("%0s gave up after %0d reads without the expected value",
                        v_name[i], POLL_READS);
               ok = 1'b0;
            end
         end
         OP_W'("srst"): begin
            bus_access(v_addr[i], v_data[i], v_strb[i], act, ok);
            act = '0;
            // Pulse covers exactly the cycle after the ack
            @(posedge clk);
            act[1] = cpu_reset;
            @(posedge clk);
            act[0] = cpu_reset;
         end
         OP_W'("rts"): begin
            @(posedge clk);
            act = DATA_W'(uart_rts);
         end
         OP_W'("cts"): begin
            @(negedge clk);
            uart_cts = v_data[i][0];
            checked  = 1'b0;
         end
         OP_W'("wait"): begin
            repeat (v_data[i]) @(posedge clk);
            checked = 1'b0;
         end
         default: begin
            $display("%0s has an unknown operation %0s", v_name[i], v_op[i]);
            ok = 1'b0;
         end
      endcase
      if (!ok) begin
         $display("FAIL %0s", v_name[i]);
         fail_count++;
      end else if (checked && act !== v_exp[i]) begin
         $display("ERR %0s expected %h actual %h", v_name[i], v_exp[i], act);
         fail_count++;
      end else begin
         $display("PASS %0s", v_name[i]);
         pass_count++;
      end
   endtask

   initial begin
      reset      = 1'b1;
      mem_valid  = 1'b0;
      mem_addr   = '0;
      mem_wdata  = '0;
      mem_wstrb  = '0;
      uart_cts   = 1'b1;
      n_vec      = 0;
      pass_count = 0;
      fail_count = 0;
      void'($urandom(32'h25b));

      // Columns are name, op, addr, data, strobe, expected
      fd = $fopen("tb/soc_vectors.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the vector file tb/soc_vectors.txt");
         fail_count++;
      end else begin
         while (n_vec < MAX_VEC &&
                $fscanf(fd, "%s %s %h %h %h %h", v_name[n_vec], v_op[n_vec], v_addr[n_vec],
                        v_data[n_vec], v_strb[n_vec], v_exp[n_vec]) == 6)
            n_vec++;
         $fclose(fd);
      end
      vectors_loaded = 1'b1;

      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      for (int i = 0; i < n_vec; i++)
         run_vector(i);

      $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0 && n_vec > 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // Watchdog sized from the vector count and the worst poll
   initial begin
      wait (vectors_loaded);
      #((n_vec + 1) * POLL_CYCLES * CLK_PERIOD);
      $display("Watchdog expired before all vectors finished");
      $display("Regression failed");
      $finish;
   end

endmodule

// File: vlog.f
verilog/soc_pkg.sv
verilog/mem_bus_if.sv
verilog/sp_ram.sv
verilog/uart_core.sv
verilog/bus_decoder.sv
verilog/soc_top.sv
tb/tb_soc.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 --top-module tb_soc -o tb_soc -f vlog.f \
   && ./obj_dir/tb_soc > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation aborted"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && { echo "Simulation reported failure"; exit 1; } || exit 0

// File: tb/soc_vectors.txt
rts_idle        rts  0000 00000000 0 00000001
ram_word0       wr   4010 11223344 f 00000000
ram_word1       wr   4014 aabbccdd f 00000000
ram_word2       wr   4018 cafef00d f 00000000
ram_byte0       wr   4010 000000ee 1 00000000
ram_byte2       wr   4010 00990000 4 00000000
ram_half_hi     wr   4014 12345678 c 00000000
ram_half_lo     wr   4014 0000beef 3 00000000
ram_byte3       wr   4018 7f000000 8 00000000
ram_check0      rd   4010 00000000 0 119933ee
ram_check1      rd   4014 00000000 0 1234beef
ram_check2      rd   4018 00000000 0 7ffef00d
boot_write      wr   0010 0badc0de f 00000000
boot_read       rd   2010 00000000 0 0badc0de
boot_alias      rd   2410 00000000 0 0badc0de
boot_ram_kept   rd   4010 00000000 0 119933ee
srst_pulse      srst 8000 00000001 f 00000002
remap_ram0      rd   0010 00000000 0 119933ee
remap_ram1      rd   0014 00000000 0 1234beef
remap_boot      rd   2010 00000000 0 0badc0de
uart_div_reset  rd   6000 00000000 0 0000000f
uart_div_set    wr   6000 00000003 f 00000000
uart_tx_first   wr   6004 0000005a f 00000000
uart_tx_busy    rd   6008 00000000 0 00000001
uart_tx_drop    wr   6004 000000c3 f 00000000
uart_rx_poll    poll 6010 00000000 0 00000001
uart_rts_full   rts  0000 00000000 0 00000000
uart_rx_data    rd   600c 00000000 0 0000005a
uart_rx_clear   rd   6010 00000000 0 00000000
uart_rts_free   rts  0000 00000000 0 00000001
uart_drop_wait  wait 0000 0000003c 0 00000000
uart_no_second  rd   6010 00000000 0 00000000
cts_low         cts  0000 00000000 0 00000000
cts_tx          wr   6004 00000096 f 00000000
cts_pending     rd   6008 00000000 0 00000001
cts_wait        wait 0000 00000030 0 00000000
cts_held        rd   6010 00000000 0 00000000
cts_high        cts  0000 00000001 0 00000000
cts_rx_poll     poll 6010 00000000 0 00000001
cts_rx_data     rd   600c 00000000 0 00000096
unmap_rd5       rd   a000 00000000 0 00000000
unmap_rd6       rd   c004 00000000 0 00000000
unmap_rd7       rd   e008 00000000 0 00000000
srst_rd         rd   8000 00000000 0 00000000
unmap_wr6       wr   c010 deadbeef f 00000000
unmap_ram_kept  rd   4010 00000000 0 119933ee
unmap_boot_kept rd   2010 00000000 0 0badc0de
